/* scr_pkg.sv */
/*
  Shared sizes and reset constants for the scrambled word memory.
  KEY_W must stay twice DATA_W and NONCE_W equal to DATA_W, since the
  keystream folds both key halves and the nonce into one word.
*/
package scr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Storage geometry
  //////////////////////////////////////////////////////////////////////

  // Word width on the bus and in the array
  localparam int unsigned DATA_W = 32;

  // Word address without byte lanes
  localparam int unsigned ADDR_W = 4;

  localparam int unsigned NUM_WORDS = 2 ** ADDR_W;

  //////////////////////////////////////////////////////////////////////
  // Scrambling key material
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned KEY_W   = 64;
  localparam int unsigned NONCE_W = 32;

  // Key and nonce in force from reset until the first key source answer
  localparam logic [KEY_W-1:0]   RND_CNST_KEY   = 64'h3b9f_2c61_d4e8_07a5;
  localparam logic [NONCE_W-1:0] RND_CNST_NONCE = 32'h5a1c_e38d;

endpackage

/* scr_key_manager.sv */
/*
  Holds the scrambling key and nonce and runs the refresh request.
  An invalidate drops key valid until the key source answers; the source
  may take any number of cycles.
*/
`timescale 1ns/100ps

module scr_key_manager import scr_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               inval_i,

  // Key source
  input  logic               key_valid_i,
  input  logic [KEY_W-1:0]   key_i,
  input  logic [NONCE_W-1:0] nonce_i,
  output logic               scr_req_o,

  // Towards the bank and the bus port
  output logic               key_valid_o,
  output logic [KEY_W-1:0]   key_o,
  output logic [NONCE_W-1:0] nonce_o
);

  logic req_d, req_q;
  logic key_valid_d, key_valid_q;

  // Request stays up until the source answers
  assign req_d = req_q ? ~key_valid_i : inval_i;

  // Key usable again once the answer to a pending request arrives
  assign key_valid_d = req_q   ? key_valid_i :
                       inval_i ? 1'b0        :
                                 key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  // Any answer from the source replaces the key even without a request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_o   <= RND_CNST_KEY;
      nonce_o <= RND_CNST_NONCE;
    end else if (key_valid_i) begin
      key_o   <= key_i;
      nonce_o <= nonce_i;
    end
  end

  assign scr_req_o   = req_q;
  assign key_valid_o = key_valid_q;

endmodule

/* scr_ram_bank.sv */
/*
  Single-port word store scrambled with a keystream from key, nonce and address.
  Contents are not cleared and read back altered after a key change.
  The keystream is weak by design and gives no real confidentiality.
*/
`timescale 1ns/100ps

module scr_ram_bank import scr_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               req_i,
  input  logic               we_i,
  input  logic [ADDR_W-1:0]  addr_i,
  input  logic [DATA_W-1:0]  wdata_i,

  input  logic [KEY_W-1:0]   key_i,
  input  logic [NONCE_W-1:0] nonce_i,

  output logic [DATA_W-1:0]  rdata_o
);

  logic [DATA_W-1:0] mem_q [NUM_WORDS];
  logic [DATA_W-1:0] key_hi;
  logic [DATA_W-1:0] key_lo;
  logic [DATA_W-1:0] keystream;
  logic [DATA_W-1:0] rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Keystream
  //////////////////////////////////////////////////////////////////////

  assign key_hi = key_i[KEY_W-1:KEY_W/2];
  assign key_lo = key_i[KEY_W/2-1:0];

  // Address folded in so equal data at two words stores differently
  assign keystream = key_hi ^ key_lo ^ nonce_i ^ DATA_W'(addr_i);

  //////////////////////////////////////////////////////////////////////
  // Array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i ^ keystream;
    end
  end

  // Descramble with the key in force at the read request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i] ^ keystream;
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* scr_wb_port.sv */
/*
  Wishbone classic slave for full words only and without wait states.
  Every sampled request ends one cycle later with ack, or with err while the
  key is invalid; the master must drop stb or change request after a termination.
*/
`timescale 1ns/100ps

module scr_wb_port import scr_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Wishbone slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  output logic [DATA_W-1:0] wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,

  input  logic              key_valid_i,

  // Memory side
  output logic              mem_req_o,
  output logic              mem_we_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  logic new_req;
  logic ack_d, ack_q;
  logic err_d, err_q;

  //////////////////////////////////////////////////////////////////////
  // Request detection and termination
  //////////////////////////////////////////////////////////////////////

  // A registered termination means this request is already answered
  assign new_req = wb_cyc_i & wb_stb_i & ~(ack_q | err_q);

  assign ack_d = new_req & key_valid_i;
  assign err_d = new_req & ~key_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
      err_q <= err_d;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

  //////////////////////////////////////////////////////////////////////
  // Memory access
  //////////////////////////////////////////////////////////////////////

  // Rejected accesses never reach the array
  assign mem_req_o   = ack_d;
  assign mem_we_o    = wb_we_i;
  assign mem_addr_o  = wb_adr_i;
  assign mem_wdata_o = wb_dat_i;

  // Bank data lands in the ack cycle
  assign wb_dat_o = mem_rdata_i;

endmodule

/* scr_mem_top.sv */
/*
  Scrambled word memory behind a Wishbone classic slave with key refresh.
  Accesses end in err from an invalidate until the key source answers.
*/
`timescale 1ns/100ps

module scr_mem_top import scr_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Wishbone slave
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  logic [ADDR_W-1:0]  wb_adr_i,
  input  logic [DATA_W-1:0]  wb_dat_i,
  output logic [DATA_W-1:0]  wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,

  // Key source
  input  logic               inval_i,
  output logic               scr_req_o,
  input  logic               key_valid_i,
  input  logic [KEY_W-1:0]   key_i,
  input  logic [NONCE_W-1:0] nonce_i
);

  logic               key_valid;
  logic [KEY_W-1:0]   key;
  logic [NONCE_W-1:0] nonce;

  logic               mem_req;
  logic               mem_we;
  logic [ADDR_W-1:0]  mem_addr;
  logic [DATA_W-1:0]  mem_wdata;
  logic [DATA_W-1:0]  mem_rdata;

  scr_key_manager u_key_manager (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .inval_i    (inval_i),
    .key_valid_i(key_valid_i),
    .key_i      (key_i),
    .nonce_i    (nonce_i),
    .scr_req_o  (scr_req_o),
    .key_valid_o(key_valid),
    .key_o      (key),
    .nonce_o    (nonce)
  );

  scr_ram_bank u_ram_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req),
    .we_i   (mem_we),
    .addr_i (mem_addr),
    .wdata_i(mem_wdata),
    .key_i  (key),
    .nonce_i(nonce),
    .rdata_o(mem_rdata)
  );

  scr_wb_port u_wb_port (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .key_valid_i(key_valid),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata)
  );

endmodule

/* tb_clk_gen.sv */
/*
  Free-running 10 ns clock and a reset held low for the first 16 cycles.
*/
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released on a falling edge away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* scr_mem_checker.sv */
/*
  Bus and key handshake properties bound to scr_mem_top.
  Checked on the rising clock edge outside reset.
*/
`timescale 1ns/100ps

module scr_mem_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic wb_err_o,
  input logic scr_req_o,
  input logic key_valid_i
);

  ack_err_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(wb_ack_o && wb_err_o)
  ) else $error("ack and err are high in the same cycle");

  // Termination answers a request sampled one cycle earlier
  term_after_request: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i)
  ) else $error("termination without a request in the cycle before");

  req_drop_after_key: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $fell(scr_req_o) |-> $past(key_valid_i)
  ) else $error("key request dropped without a key answer");

endmodule

/* scr_mem_tb.sv */
/*
  Random accesses against a model of the scrambled store across key refreshes.
  Inputs change and outputs are sampled on the falling clock edge.
*/
`timescale 1ns/100ps

module scr_mem_tb import scr_pkg::*; ();

  localparam logic [63:0] RESET_KEY   = 64'h3b9f_2c61_d4e8_07a5;
  localparam logic [31:0] RESET_NONCE = 32'h5a1c_e38d;
  localparam int          TIMEOUT     = 20;

  logic clk, rst_n;
  logic wb_cyc, wb_stb, wb_we, wb_ack_o, wb_err_o;
  logic [ADDR_W-1:0]  wb_adr;
  logic [DATA_W-1:0]  wb_dat, wb_dat_o;
  logic inval, scr_req_o, key_valid;
  logic [KEY_W-1:0]   key_in;
  logic [NONCE_W-1:0] nonce_in;

  // Model of raw stored words and the key the DUT should hold
  logic [DATA_W-1:0]  raw_mem [NUM_WORDS];
  logic [KEY_W-1:0]   cur_key;
  logic [NONCE_W-1:0] cur_nonce;
  integer seed;
  int check_count, error_count, timeout_count;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  scr_mem_top UUT (
    .clk_i(clk), .rst_ni(rst_n),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
    .inval_i(inval), .scr_req_o(scr_req_o), .key_valid_i(key_valid),
    .key_i(key_in), .nonce_i(nonce_in)
  );

  bind scr_mem_top scr_mem_checker u_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .scr_req_o(scr_req_o),
    .key_valid_i(key_valid_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Model and checking
  //////////////////////////////////////////////////////////////////////

  // Both key halves, nonce and zero-extended word address
  function automatic logic [DATA_W-1:0] keystream(input logic [ADDR_W-1:0] adr);
    keystream = cur_key[63:32] ^ cur_key[31:0] ^ cur_nonce ^ {28'h0, adr};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic bus_access(input string name, input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdat, input logic exp_ack);
    int cycles;
    logic [DATA_W-1:0] exp_rdat;
    cycles = 0;
    exp_rdat = raw_mem[adr] ^ keystream(adr);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdat;
    while (!(wb_ack_o || wb_err_o) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!(wb_ack_o || wb_err_o)) begin
      $display("timeout: %s at word %0d got neither ack nor err", name, adr);
      timeout_count++;
    end else begin
      check_value($sformatf("%s ack", name), 64'(exp_ack), 64'(wb_ack_o));
      check_value($sformatf("%s err", name), 64'(!exp_ack), 64'(wb_err_o));
      check_value($sformatf("%s latency", name), 64'd1, 64'(cycles));
      if (exp_ack && !we) begin
        check_value($sformatf("%s data word %0d", name, adr), 64'(exp_rdat), 64'(wb_dat_o));
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // Accepted writes land scrambled under the key in force
    if (we && exp_ack) begin
      raw_mem[adr] = wdat ^ keystream(adr);
    end
  endtask

  task automatic random_access(input string name, input logic exp_ack);
    logic [31:0] rnd;
    rnd = $random(seed);
    bus_access(name, rnd[31], rnd[ADDR_W-1:0], $random(seed), exp_ack);
  endtask

  task automatic read_all(input string name);
    for (int i = 0; i < NUM_WORDS; i++) begin
      bus_access(name, 1'b0, ADDR_W'(i), '0, 1'b1);
    end
  endtask

  task automatic wait_req(input logic level);
    int waited;
    waited = 0;
    while (scr_req_o !== level && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (scr_req_o !== level) begin
      $display("timeout: scr_req_o never reached %0b", level);
      timeout_count++;
    end
  endtask

  // One-cycle answer from the key source
  task automatic load_key();
    logic [KEY_W-1:0]   key;
    logic [NONCE_W-1:0] nonce;
    key   = {$random(seed), $random(seed)};
    nonce = $random(seed);
    @(negedge clk);
    key_valid = 1'b1;
    key_in    = key;
    nonce_in  = nonce;
    @(negedge clk);
    key_valid = 1'b0;
    cur_key   = key;
    cur_nonce = nonce;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int waited;
    seed = 32'h66dd2c70;
    {wb_cyc, wb_stb, wb_we, inval, key_valid} = '0;
    wb_adr = '0;
    wb_dat = '0;
    key_in = '0;
    nonce_in = '0;
    cur_key = RESET_KEY;
    cur_nonce = RESET_NONCE;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      timeout_count++;
    end
    check_value("ack after reset", '0, 64'(wb_ack_o));
    check_value("err after reset", '0, 64'(wb_err_o));
    check_value("scr_req after reset", '0, 64'(scr_req_o));

    for (int i = 0; i < NUM_WORDS; i++) begin
      bus_access("fill", 1'b1, ADDR_W'(i), $random(seed), 1'b1);
    end
    repeat (30) random_access("reset key", 1'b1);

    @(negedge clk);
    inval = 1'b1;
    @(negedge clk);
    inval = 1'b0;
    wait_req(1'b1);
    repeat (12) random_access("invalid key", 1'b0);
    check_value("scr_req while refreshing", 64'd1, 64'(scr_req_o));

    // Old raw words seen through the new keystream
    load_key();
    wait_req(1'b0);
    read_all("requested key");
    repeat (30) random_access("refreshed key", 1'b1);

    load_key();
    check_value("scr_req after unrequested key", '0, 64'(scr_req_o));
    read_all("unrequested key");

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* scr_mem_top.f */
scr_pkg.sv
scr_key_manager.sv
scr_ram_bank.sv
scr_wb_port.sv
scr_mem_top.sv
tb_clk_gen.sv
scr_mem_checker.sv
scr_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds scr_mem_tb with Verilator, runs it and scans the log for the verdict
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f scr_mem_top.f --top-module scr_mem_tb \
  -Mdir obj_dir -o scr_mem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/scr_mem_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation binary exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$log_file"; then
  echo "No verdict found in $log_file"
  exit 1
fi
exit 0
